// File: Makefile
VERILATOR ?= verilator
TOP       ?= cache_tb
RTL_TOP   ?= cache_top
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
PASS_MSG  ?= Testbench passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# the run passes only if the log holds the pass line
sim: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    localparam int    CLK_PERIOD      = 4;
    localparam int    RESET_CYCLES    = 8;
    localparam int    NUM_TESTS       = 6;
    localparam int    CYCLES_PER_TEST = 200;
    localparam int    MARGIN_CYCLES   = 200;
    localparam int    RAND_SEED       = 62;
    localparam word_t FILL_KEY        = 32'h5a3c_96e1;
    localparam lfsr_t LFSR_START      = 8'h01;

    logic    clk = 1'b0;
    logic    resetn;
    logic    valid;
    logic    op;
    index_t  index;
    tag_t    tag;
    offset_t offset;
    strb_t   wstrb;
    word_t   wdata;
    logic    addr_ok;
    logic    data_ok;
    word_t   rdata;
    logic    rd_req;
    addr_t   rd_addr;
    logic    rd_rdy;
    logic    ret_valid;
    logic    ret_last;
    word_t   ret_data;
    logic    wr_req;
    addr_t   wr_addr;
    line_t   wr_data;
    logic    wr_rdy;

    // reference cache state
    logic  ref_valid [2][256];
    logic  ref_dirty [2][256];
    tag_t  ref_tag   [2][256];
    line_t ref_line  [2][256];
    word_t ref_mem   [addr_t];
    lfsr_t ref_lfsr;

    int    rd_count = 0;
    int    wr_count = 0;
    int    xfer_seq = 0;
    int    last_rd_seq = 0;
    int    last_wr_seq = 0;
    addr_t last_rd_addr = '0;
    addr_t last_wr_addr = '0;
    line_t last_wr_data = '0;
    int    errors = 0;
    int    tests_run = 0;
    int    tests_failed = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    cache_top i_dut (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .index(index), .tag(tag),
        .offset(offset), .wstrb(wstrb), .wdata(wdata), .addr_ok(addr_ok),
        .data_ok(data_ok), .rdata(rdata), .rd_req(rd_req), .rd_addr(rd_addr),
        .rd_rdy(rd_rdy), .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    mem_model #(.FILL_KEY(FILL_KEY), .SEED(RAND_SEED)) i_mem (
        .clk(clk), .resetn(resetn), .rd_req(rd_req), .rd_addr(rd_addr), .rd_rdy(rd_rdy),
        .ret_valid(ret_valid), .ret_last(ret_last), .ret_data(ret_data),
        .wr_req(wr_req), .wr_addr(wr_addr), .wr_data(wr_data), .wr_rdy(wr_rdy)
    );

    // memory transfers in order
    always @(posedge clk) begin
        if (wr_req && wr_rdy) begin
            wr_count     <= wr_count + 1;
            last_wr_addr <= wr_addr;
            last_wr_data <= wr_data;
            last_wr_seq  <= xfer_seq;
            xfer_seq     <= xfer_seq + 1;
        end else if (rd_req && rd_rdy) begin
            rd_count     <= rd_count + 1;
            last_rd_addr <= rd_addr;
            last_rd_seq  <= xfer_seq;
            xfer_seq     <= xfer_seq + 1;
        end
    end

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, strb_t strb);
        word_t result;
        result = old_word;
        for (int k = 0; k < 4; k++) begin
            if (strb[k]) begin
                result[8*k +: 8] = new_word[8*k +: 8];
            end
        end
        return result;
    endfunction

    function automatic word_t mem_word(addr_t a);
        if (ref_mem.exists(a)) begin
            return ref_mem[a];
        end
        return a ^ FILL_KEY;
    endfunction

    task automatic flag_error(input string msg);
        errors++;
        $display("error at %0d ns: %s", $time, msg);
    endtask

    task automatic finish_test(input string name, input int errors_at_start);
        tests_run++;
        if (errors > errors_at_start) begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errors - errors_at_start);
        end else begin
            $display("test %s: ok", name);
        end
    endtask

    task automatic clear_reference();
        for (int w = 0; w < 2; w++) begin
            for (int s = 0; s < 256; s++) begin
                ref_valid[w][s] = 1'b0;
                ref_dirty[w][s] = 1'b0;
            end
        end
        ref_lfsr = LFSR_START;
    endtask

    // one request predicted by the reference and checked against it
    task automatic run_access(input logic is_store, input addr_t a, input strb_t strb,
                              input word_t wd);
        tag_t   t;
        index_t idx;
        bank_t  bk;
        logic   hit_found;
        logic   way;
        logic   exp_wb;
        addr_t  line_addr;
        addr_t  wb_addr;
        line_t  wb_line;
        line_t  line;
        word_t  exp_word;
        word_t  got;
        int     rd_before;
        int     wr_before;
        int     edges;
        t         = a[31:12];
        idx       = a[11:4];
        bk        = a[3:2];
        line_addr = {t, idx, 4'h0};
        hit_found = 1'b0;
        way       = 1'b0;
        exp_wb    = 1'b0;
        wb_addr   = '0;
        wb_line   = '0;
        for (int w = 0; w < 2; w++) begin
            if (!hit_found && ref_valid[w][idx] && ref_tag[w][idx] == t) begin
                hit_found = 1'b1;
                way       = w[0];
            end
        end
        if (hit_found) begin
            line = ref_line[way][idx];
        end else begin
            way = ref_lfsr[0];  // victim whether valid or not
            if (ref_valid[way][idx] && ref_dirty[way][idx]) begin
                exp_wb  = 1'b1;
                wb_addr = {ref_tag[way][idx], idx, 4'h0};
                wb_line = ref_line[way][idx];
                for (int k = 0; k < 4; k++) begin
                    ref_mem[wb_addr + addr_t'(4 * k)] = wb_line[32*k +: 32];
                end
            end
            for (int k = 0; k < 4; k++) begin
                line[32*k +: 32] = mem_word(line_addr + addr_t'(4 * k));
            end
            ref_valid[way][idx] = 1'b1;
            ref_tag[way][idx]   = t;
            ref_dirty[way][idx] = 1'b0;
            ref_lfsr = {ref_lfsr[6:0], ref_lfsr[7] ^ ref_lfsr[5] ^ ref_lfsr[4] ^ ref_lfsr[3]};
        end
        exp_word = line[32*bk +: 32];
        if (is_store) begin
            line[32*bk +: 32]   = merge_bytes(exp_word, wd, strb);
            ref_dirty[way][idx] = 1'b1;
        end
        ref_line[way][idx] = line;

        rd_before = rd_count;
        wr_before = wr_count;
        valid  <= 1'b1;
        op     <= is_store;
        tag    <= t;
        index  <= idx;
        offset <= a[3:0];
        wstrb  <= strb;
        wdata  <= wd;
        @(posedge clk);
        while (!addr_ok) begin
            @(posedge clk);
        end
        valid <= 1'b0;
        edges = 0;
        do begin
            @(posedge clk);
            edges++;
        end while (!data_ok);
        got = rdata;

        if (rd_count - rd_before != (hit_found ? 0 : 1)) begin
            flag_error($sformatf("addr %08h: %0d line reads, expected %0d", a,
                                 rd_count - rd_before, hit_found ? 0 : 1));
        end
        if (!hit_found && last_rd_addr != line_addr) begin
            flag_error($sformatf("rd_addr %08h, expected %08h", last_rd_addr, line_addr));
        end
        if (wr_count - wr_before != (exp_wb ? 1 : 0)) begin
            flag_error($sformatf("addr %08h: %0d write-backs, expected %0d", a,
                                 wr_count - wr_before, exp_wb ? 1 : 0));
        end
        if (exp_wb && last_wr_addr != wb_addr) begin
            flag_error($sformatf("wr_addr %08h, expected %08h", last_wr_addr, wb_addr));
        end
        if (exp_wb && last_wr_data != wb_line) begin
            flag_error($sformatf("wr_data %032h, expected %032h", last_wr_data, wb_line));
        end
        if (exp_wb && last_wr_seq > last_rd_seq) begin
            flag_error($sformatf("addr %08h: write-back came after the line read", a));
        end
        // data_ok rose one edge before the edge that saw it
        if (hit_found && edges - 1 != 2) begin
            flag_error($sformatf("hit answered %0d cycles after acceptance, expected 2",
                                 edges - 1));
        end
        if (!is_store && got != exp_word) begin
            flag_error($sformatf("addr %08h: rdata %08h, expected %08h", a, got, exp_word));
        end
    endtask

    task automatic check_reset_state();
        int e0;
        e0 = errors;
        if (!addr_ok) flag_error("addr_ok is low after reset");
        if (data_ok) flag_error("data_ok is high after reset");
        if (rd_req) flag_error("rd_req is high after reset");
        if (wr_req) flag_error("wr_req is high after reset");
        finish_test("reset state", e0);
    endtask

    task automatic read_miss_then_hit();
        int e0;
        e0 = errors;
        run_access(1'b0, 32'h0001_2344, 4'h0, 32'h0);  // cold miss
        run_access(1'b0, 32'h0001_2348, 4'h0, 32'h0);
        finish_test("read miss then hit", e0);
    endtask

    task automatic store_hit_merge();
        int e0;
        e0 = errors;
        run_access(1'b0, 32'h0003_4560, 4'h0, 32'h0);
        run_access(1'b1, 32'h0003_4564, 4'b0110, 32'ha5a5_5a5a);
        run_access(1'b0, 32'h0003_4564, 4'h0, 32'h0);
        run_access(1'b1, 32'h0003_4564, 4'b1001, 32'h1122_3344);
        run_access(1'b0, 32'h0003_4564, 4'h0, 32'h0);
        finish_test("store hit merge", e0);
    endtask

    task automatic store_miss_merge();
        int e0;
        e0 = errors;
        run_access(1'b1, 32'h0005_6788, 4'b1100, 32'hdead_beef);
        run_access(1'b0, 32'h0005_6780, 4'h0, 32'h0);  // untouched word
        run_access(1'b0, 32'h0005_6788, 4'h0, 32'h0);
        finish_test("store miss merge", e0);
    endtask

    task automatic dirty_eviction();
        addr_t lines [3] = '{32'h0010_0404, 32'h0020_0404, 32'h0030_0404};
        int    e0;
        int    wr_start;
        e0       = errors;
        wr_start = wr_count;
        for (int i = 0; i < 3; i++) begin
            run_access(1'b1, lines[i], 4'hf, 32'hc0de_0000 ^ lines[i]);
        end
        for (int i = 0; i < 3; i++) begin
            run_access(1'b0, lines[i], 4'h0, 32'h0);
            run_access(1'b0, lines[i] & ~32'hf, 4'h0, 32'h0);
        end
        if (wr_count == wr_start) begin
            flag_error("no write-back while three dirty lines shared one set");
        end
        finish_test("dirty eviction", e0);
    endtask

    task automatic clean_eviction();
        addr_t lines [3] = '{32'h0040_0800, 32'h0050_0800, 32'h0060_0800};
        int    e0;
        int    wr_start;
        e0       = errors;
        wr_start = wr_count;
        for (int i = 0; i < 6; i++) begin
            run_access(1'b0, lines[i % 3], 4'h0, 32'h0);
        end
        if (wr_count != wr_start) begin
            flag_error("evicting clean lines wrote back to memory");
        end
        finish_test("clean eviction", e0);
    endtask

    initial begin
        #((NUM_TESTS * CYCLES_PER_TEST + RESET_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
        $display("watchdog expired at %0d ns, the cache stopped answering", $time);
        $display("Testbench failed");
        $finish;
    end

    initial begin
        resetn <= 1'b0;
        valid  <= 1'b0;
        op     <= 1'b0;
        index  <= '0;
        tag    <= '0;
        offset <= '0;
        wstrb  <= '0;
        wdata  <= '0;
        clear_reference();
        repeat (RESET_CYCLES) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        check_reset_state();
        read_miss_then_hit();
        store_hit_merge();
        store_miss_merge();
        dirty_eviction();
        clean_eviction();
        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: bench/mem_model.sv
module mem_model #(
    parameter cache_pkg::word_t FILL_KEY = 32'h0,
    parameter int               SEED     = 1
) (
    input  logic             clk,
    input  logic             resetn,
    input  logic             rd_req,
    input  cache_pkg::addr_t rd_addr,
    output logic             rd_rdy,
    output logic             ret_valid,
    output logic             ret_last,
    output cache_pkg::word_t ret_data,
    input  logic             wr_req,
    input  cache_pkg::addr_t wr_addr,
    input  cache_pkg::line_t wr_data,
    output logic             wr_rdy
);
    timeunit 1ns;
    timeprecision 100ps;
    import cache_pkg::*;

    word_t mem_words [addr_t];  // only written words live here

    function automatic word_t read_word(addr_t a);
        if (mem_words.exists(a)) begin
            return mem_words[a];
        end
        return a ^ FILL_KEY;
    endfunction

    initial begin
        int    rd_wait;
        int    wr_wait;
        addr_t base;
        rd_rdy    <= 1'b0;
        ret_valid <= 1'b0;
        ret_last  <= 1'b0;
        ret_data  <= '0;
        wr_rdy    <= 1'b0;
        void'($urandom(SEED));
        fork
            forever begin  // line reads
                @(posedge clk);
                if (resetn && rd_req) begin
                    rd_wait = $urandom_range(3, 0);
                    repeat (rd_wait) @(posedge clk);
                    rd_rdy <= 1'b1;
                    base = rd_addr;
                    @(posedge clk);
                    rd_rdy <= 1'b0;
                    for (int w = 0; w < 4; w++) begin
                        ret_valid <= 1'b1;
                        ret_last  <= (w == 3);
                        ret_data  <= read_word(base + addr_t'(4 * w));
                        @(posedge clk);
                    end
                    ret_valid <= 1'b0;
                    ret_last  <= 1'b0;
                end
            end
            forever begin  // write-backs
                @(posedge clk);
                if (resetn && wr_req) begin
                    wr_wait = $urandom_range(3, 0);
                    repeat (wr_wait) @(posedge clk);
                    wr_rdy <= 1'b1;
                    @(posedge clk);
                    wr_rdy <= 1'b0;
                    for (int w = 0; w < 4; w++) begin
                        mem_words[wr_addr + addr_t'(4 * w)] = wr_data[32*w +: 32];
                    end
                end
            end
        join
    end

endmodule

// File: src/cache_ctrl.sv
module cache_ctrl (
    input  logic              clk,
    input  logic              resetn,
    input  logic              req_new,
    input  logic              req_op,
    input  cache_pkg::index_t  req_index,
    input  cache_pkg::tag_t    req_tag,
    input  cache_pkg::offset_t req_offset,
    input  cache_pkg::strb_t   req_wstrb,
    input  cache_pkg::word_t   req_wdata,
    input  logic              refill_done,
    input  cache_pkg::line_t   refill_line,
    input  cache_pkg::tag_t    w0_rd_tag,
    input  logic              w0_rd_valid,
    input  logic              w0_rd_dirty,
    input  cache_pkg::line_t   w0_rd_line,
    input  cache_pkg::tag_t    w1_rd_tag,
    input  logic              w1_rd_valid,
    input  logic              w1_rd_dirty,
    input  cache_pkg::line_t   w1_rd_line,
    output logic              data_ok,
    output cache_pkg::word_t   rdata,
    output logic              done,
    output logic              miss_start,
    output cache_pkg::tag_t    victim_tag,
    output cache_pkg::line_t   victim_line,
    output logic              victim_dirty,
    output logic              w0_fill_en,
    output logic              w1_fill_en,
    output logic              w0_store_en,
    output logic              w1_store_en,
    output cache_pkg::tag_t    fill_tag,
    output cache_pkg::line_t   fill_line,
    output logic              fill_dirty,
    output cache_pkg::bank_t   store_bank,
    output cache_pkg::strb_t   store_wstrb,
    output cache_pkg::word_t   store_wdata
);
    import cache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t state_next;
    lfsr_t       lfsr;
    logic        w0_hit;
    logic        w1_hit;
    logic        hit;
    logic        victim_way;
    bank_t       bank;
    line_t       hit_line;
    line_t       merged_line;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            IDLE:    if (req_new) state_next = READ;
            READ:    state_next = LOOKUP;
            LOOKUP:  state_next = hit ? IDLE : MISS;
            MISS:    if (refill_done) state_next = FILL;
            FILL:    state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    // tag compare
    assign w0_hit   = w0_rd_valid && (w0_rd_tag == req_tag);
    assign w1_hit   = w1_rd_valid && (w1_rd_tag == req_tag);
    assign hit      = w0_hit || w1_hit;
    assign hit_line = w0_hit ? w0_rd_line : w1_rd_line;
    assign bank     = req_offset[3:2];

    // store bytes laid over the refilled word
    always_comb begin
        word_t old_word;
        word_t new_word;
        merged_line = refill_line;
        old_word    = refill_line[bank*$bits(word_t) +: $bits(word_t)];
        new_word    = old_word;
        for (int k = 0; k < $bits(strb_t); k++) begin
            if (req_op && req_wstrb[k]) begin
                new_word[k*8 +: 8] = req_wdata[k*8 +: 8];
            end
        end
        merged_line[bank*$bits(word_t) +: $bits(word_t)] = new_word;
    end

    assign data_ok = (state == LOOKUP && hit) || state == FILL;
    assign done    = data_ok;
    assign rdata   = (state == FILL) ? merged_line[bank*$bits(word_t) +: $bits(word_t)]
                                     : hit_line[bank*$bits(word_t) +: $bits(word_t)];

    assign victim_way   = lfsr[0];
    assign miss_start   = state == LOOKUP && !hit;
    assign victim_tag   = victim_way ? w1_rd_tag : w0_rd_tag;
    assign victim_line  = victim_way ? w1_rd_line : w0_rd_line;
    assign victim_dirty = victim_way ? (w1_rd_valid && w1_rd_dirty)
                                     : (w0_rd_valid && w0_rd_dirty);

    // array writes
    assign w0_store_en = state == LOOKUP && req_op && w0_hit;
    assign w1_store_en = state == LOOKUP && req_op && w1_hit && !w0_hit;
    assign w0_fill_en  = state == FILL && !victim_way;
    assign w1_fill_en  = state == FILL && victim_way;
    assign fill_tag    = req_tag;
    assign fill_line   = merged_line;
    assign fill_dirty  = req_op;
    assign store_bank  = bank;
    assign store_wstrb = req_wstrb;
    assign store_wdata = req_wdata;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            lfsr <= LFSR_SEED;
        end else if (state == FILL) begin
            lfsr <= {lfsr[6:0], ^(lfsr & LFSR_TAPS)};
        end
    end

endmodule

// File: src/cache_pkg.sv
package cache_pkg;

    typedef logic [19:0]  tag_t;
    typedef logic [7:0]   index_t;
    typedef logic [3:0]   offset_t;  // [3:2] picks the bank
    typedef logic [1:0]   bank_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   strb_t;
    typedef logic [127:0] line_t;    // word 0 in the low bits
    typedef logic [31:0]  addr_t;
    typedef logic [7:0]   lfsr_t;

    localparam int unsigned NUM_BANKS = 4;
    localparam int unsigned NUM_SETS  = 256;

    // replacement lfsr
    localparam lfsr_t LFSR_SEED = 8'h01;
    localparam lfsr_t LFSR_TAPS = 8'b1011_1000;  // bits 7, 5, 4, 3

    typedef enum logic [2:0] {
        IDLE,
        READ,    // wait for the registered array read
        LOOKUP,
        MISS,
        FILL
    } ctrl_state_t;

endpackage

// File: src/cache_top.sv
module cache_top (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  logic              op,
    input  cache_pkg::index_t  index,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::strb_t   wstrb,
    input  cache_pkg::word_t   wdata,
    output logic              addr_ok,
    output logic              data_ok,
    output cache_pkg::word_t   rdata,
    output logic              rd_req,
    output cache_pkg::addr_t   rd_addr,
    input  logic              rd_rdy,
    input  logic              ret_valid,
    input  logic              ret_last,
    input  cache_pkg::word_t   ret_data,
    output logic              wr_req,
    output cache_pkg::addr_t   wr_addr,
    output cache_pkg::line_t   wr_data,
    input  logic              wr_rdy
);
    import cache_pkg::*;

    logic    req_op, req_new, done;
    index_t  req_index;
    tag_t    req_tag;
    offset_t req_offset;
    strb_t   req_wstrb;
    word_t   req_wdata;
    logic    miss_start, victim_dirty, refill_done;
    tag_t    victim_tag;
    line_t   victim_line, refill_line;
    tag_t    w0_rd_tag, w1_rd_tag, fill_tag;
    logic    w0_rd_valid, w1_rd_valid, w0_rd_dirty, w1_rd_dirty;
    line_t   w0_rd_line, w1_rd_line, fill_line;
    logic    w0_fill_en, w1_fill_en, w0_store_en, w1_store_en, fill_dirty;
    bank_t   store_bank;
    strb_t   store_wstrb;
    word_t   store_wdata;

    req_buffer u_req_buffer (
        .clk(clk), .resetn(resetn), .valid(valid), .op(op), .index(index), .tag(tag),
        .offset(offset), .wstrb(wstrb), .wdata(wdata), .done(done), .addr_ok(addr_ok),
        .req_op(req_op), .req_index(req_index), .req_tag(req_tag), .req_offset(req_offset),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .req_new(req_new)
    );

    way_store way0 (
        .clk(clk), .resetn(resetn), .rd_index(req_index), .fill_en(w0_fill_en),
        .fill_tag(fill_tag), .fill_line(fill_line), .fill_dirty(fill_dirty),
        .store_en(w0_store_en), .store_bank(store_bank), .store_wstrb(store_wstrb),
        .store_wdata(store_wdata), .rd_tag(w0_rd_tag), .rd_valid(w0_rd_valid),
        .rd_dirty(w0_rd_dirty), .rd_line(w0_rd_line)
    );

    way_store way1 (
        .clk(clk), .resetn(resetn), .rd_index(req_index), .fill_en(w1_fill_en),
        .fill_tag(fill_tag), .fill_line(fill_line), .fill_dirty(fill_dirty),
        .store_en(w1_store_en), .store_bank(store_bank), .store_wstrb(store_wstrb),
        .store_wdata(store_wdata), .rd_tag(w1_rd_tag), .rd_valid(w1_rd_valid),
        .rd_dirty(w1_rd_dirty), .rd_line(w1_rd_line)
    );

    cache_ctrl u_cache_ctrl (
        .clk(clk), .resetn(resetn), .req_new(req_new), .req_op(req_op),
        .req_index(req_index), .req_tag(req_tag), .req_offset(req_offset),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata), .refill_done(refill_done),
        .refill_line(refill_line), .w0_rd_tag(w0_rd_tag), .w0_rd_valid(w0_rd_valid),
        .w0_rd_dirty(w0_rd_dirty), .w0_rd_line(w0_rd_line), .w1_rd_tag(w1_rd_tag),
        .w1_rd_valid(w1_rd_valid), .w1_rd_dirty(w1_rd_dirty), .w1_rd_line(w1_rd_line),
        .data_ok(data_ok), .rdata(rdata), .done(done), .miss_start(miss_start),
        .victim_tag(victim_tag), .victim_line(victim_line), .victim_dirty(victim_dirty),
        .w0_fill_en(w0_fill_en), .w1_fill_en(w1_fill_en), .w0_store_en(w0_store_en),
        .w1_store_en(w1_store_en), .fill_tag(fill_tag), .fill_line(fill_line),
        .fill_dirty(fill_dirty), .store_bank(store_bank), .store_wstrb(store_wstrb),
        .store_wdata(store_wdata)
    );

    mem_port u_mem_port (
        .clk(clk), .resetn(resetn), .miss_start(miss_start), .victim_tag(victim_tag),
        .victim_line(victim_line), .victim_dirty(victim_dirty), .req_tag(req_tag),
        .req_index(req_index), .wr_rdy(wr_rdy), .rd_rdy(rd_rdy), .ret_valid(ret_valid),
        .ret_last(ret_last), .ret_data(ret_data), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .rd_req(rd_req), .rd_addr(rd_addr),
        .refill_line(refill_line), .refill_done(refill_done)
    );

endmodule

// File: src/mem_port.sv
module mem_port (
    input  logic             clk,
    input  logic             resetn,
    input  logic             miss_start,
    input  cache_pkg::tag_t   victim_tag,
    input  cache_pkg::line_t  victim_line,
    input  logic             victim_dirty,
    input  cache_pkg::tag_t   req_tag,
    input  cache_pkg::index_t req_index,
    input  logic             wr_rdy,
    input  logic             rd_rdy,
    input  logic             ret_valid,
    input  logic             ret_last,
    input  cache_pkg::word_t  ret_data,
    output logic             wr_req,
    output cache_pkg::addr_t  wr_addr,
    output cache_pkg::line_t  wr_data,
    output logic             rd_req,
    output cache_pkg::addr_t  rd_addr,
    output cache_pkg::line_t  refill_line,
    output logic             refill_done
);
    import cache_pkg::*;

    tag_t  victim_tag_q;
    bank_t ret_bank;

    assign wr_addr = {victim_tag_q, req_index, offset_t'(0)};
    assign rd_addr = {req_tag, req_index, offset_t'(0)};

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wr_req      <= 1'b0;
            rd_req      <= 1'b0;
            ret_bank    <= '0;
            refill_done <= 1'b0;
        end else begin
            refill_done <= ret_valid && ret_last;
            if (miss_start) begin
                wr_req   <= victim_dirty;  // clean victims go straight to the read
                rd_req   <= !victim_dirty;
                ret_bank <= '0;
            end else if (wr_req && wr_rdy) begin
                wr_req <= 1'b0;
                rd_req <= 1'b1;
            end else if (rd_req && rd_rdy) begin
                rd_req <= 1'b0;
            end
            if (ret_valid) begin
                ret_bank <= ret_bank + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_start) begin
            victim_tag_q <= victim_tag;
            wr_data      <= victim_line;
        end
        if (ret_valid) begin
            refill_line[ret_bank*$bits(word_t) +: $bits(word_t)] <= ret_data;
        end
    end

endmodule

// File: src/req_buffer.sv
module req_buffer (
    input  logic              clk,
    input  logic              resetn,
    input  logic              valid,
    input  logic              op,
    input  cache_pkg::index_t  index,
    input  cache_pkg::tag_t    tag,
    input  cache_pkg::offset_t offset,
    input  cache_pkg::strb_t   wstrb,
    input  cache_pkg::word_t   wdata,
    input  logic              done,
    output logic              addr_ok,
    output logic              req_op,
    output cache_pkg::index_t  req_index,
    output cache_pkg::tag_t    req_tag,
    output cache_pkg::offset_t req_offset,
    output cache_pkg::strb_t   req_wstrb,
    output cache_pkg::word_t   req_wdata,
    output logic              req_new
);
    import cache_pkg::*;

    logic busy;
    logic accept;

    assign addr_ok = !busy;
    assign accept  = valid && addr_ok;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            busy    <= 1'b0;
            req_new <= 1'b0;
        end else begin
            req_new <= accept;  // kicks off the controller
            if (accept) begin
                busy <= 1'b1;
            end else if (done) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            req_op     <= op;
            req_index  <= index;
            req_tag    <= tag;
            req_offset <= offset;
            req_wstrb  <= wstrb;
            req_wdata  <= wdata;
        end
    end

endmodule

// File: src/way_store.sv
module way_store (
    input  logic             clk,
    input  logic             resetn,
    input  cache_pkg::index_t rd_index,
    input  logic             fill_en,
    input  cache_pkg::tag_t   fill_tag,
    input  cache_pkg::line_t  fill_line,
    input  logic             fill_dirty,
    input  logic             store_en,
    input  cache_pkg::bank_t  store_bank,
    input  cache_pkg::strb_t  store_wstrb,
    input  cache_pkg::word_t  store_wdata,
    output cache_pkg::tag_t   rd_tag,
    output logic             rd_valid,
    output logic             rd_dirty,
    output cache_pkg::line_t  rd_line
);
    import cache_pkg::*;

    tag_t                tag_mem  [NUM_SETS];
    word_t               data_mem [NUM_BANKS][NUM_SETS];
    logic [NUM_SETS-1:0] valid_bits;
    logic [NUM_SETS-1:0] dirty_bits;

    // status bits
    always_ff @(posedge clk) begin
        if (!resetn) begin
            valid_bits <= '0;
            dirty_bits <= '0;
            rd_valid   <= 1'b0;
            rd_dirty   <= 1'b0;
        end else begin
            if (fill_en) begin
                valid_bits[rd_index] <= 1'b1;
                dirty_bits[rd_index] <= fill_dirty;
            end else if (store_en) begin
                dirty_bits[rd_index] <= 1'b1;
            end
            rd_valid <= valid_bits[rd_index];
            rd_dirty <= dirty_bits[rd_index];
        end
    end

    // tag and data arrays
    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[rd_index] <= fill_tag;
            for (int b = 0; b < NUM_BANKS; b++) begin
                data_mem[b][rd_index] <= fill_line[b*$bits(word_t) +: $bits(word_t)];
            end
        end else if (store_en) begin
            for (int k = 0; k < $bits(strb_t); k++) begin
                if (store_wstrb[k]) begin
                    data_mem[store_bank][rd_index][k*8 +: 8] <= store_wdata[k*8 +: 8];
                end
            end
        end
        rd_tag <= tag_mem[rd_index];
        for (int b = 0; b < NUM_BANKS; b++) begin
            rd_line[b*$bits(word_t) +: $bits(word_t)] <= data_mem[b][rd_index];
        end
    end

endmodule

// File: vlog.f
src/cache_pkg.sv
src/req_buffer.sv
src/way_store.sv
src/cache_ctrl.sv
src/mem_port.sv
src/cache_top.sv
bench/mem_model.sv
bench/cache_tb.sv
